/* clock_enable_gen.sv */
`timescale 1ns/10ps

module clock_enable_gen (
	input  logic CLK_48M,
	input  logic rst,
	output logic ce_24m,
	output logic ce_12m,
	output logic ce_6m
);

	// free running divide by 8
	logic [2:0] master_cnt;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			master_cnt <= 3'd0;
		end else begin
			master_cnt <= master_cnt + 3'd1;
		end
	end

	//////////////////////////////
	// strobe decode
	//////////////////////////////

	// each strobe once per period, on the all-ones phase
	assign ce_24m = master_cnt[0];
	assign ce_12m = &master_cnt[1:0];
	// pixel clock enable, one cycle in eight
	assign ce_6m  = &master_cnt;

	// pixel strobe never stretches over two cycles
	a_ce_6m_single : assert property (
		@(posedge CLK_48M) disable iff (rst)
		ce_6m |=> !ce_6m
	);

endmodule

/* flist.f */
video_timing_pkg.sv
clock_enable_gen.sv
timing_regs.sv
horizontal_timing.sv
vertical_timing.sv
video_timing_top.sv
tb_video_timing.sv

/* horizontal_timing.sv */
`timescale 1ns/10ps

module horizontal_timing (
	input  logic                        CLK_48M,
	input  logic                        rst,
	input  logic                        ce_6m,
	input  video_timing_pkg::h_timing_t h_active,
	output logic [8:0]                  h_pos,
	output logic                        hsync_n,
	output logic                        hblank_n,
	output logic                        hreset_n,
	output logic                        line_done
);

	// line reset pixel of the original board
	localparam logic [8:0] HRESET_PIX = 9'd15;

	logic [8:0] h_cnt;
	logic [8:0] h_next;
	logic       h_wrap;

	//////////////////////////////
	// pixel counter
	//////////////////////////////

	// wrap after the programmed last pixel
	assign h_wrap = (h_cnt == h_active.line_last);
	assign h_next = h_wrap ? 9'd0 : h_cnt + 9'd1;

	// strobe on the ce_6m that wraps the count
	assign line_done = ce_6m & h_wrap;
	assign h_pos     = h_cnt;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			h_cnt <= 9'd0;
		end else if (ce_6m) begin
			h_cnt <= h_next;
		end
	end

	//////////////////////////////
	// sync and blank flops
	//////////////////////////////

	// compare against next count so edges line up with h_pos
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			hsync_n  <= 1'b1;
			hblank_n <= 1'b1;
			hreset_n <= 1'b1;
		end else if (ce_6m) begin
			// sync, falls at start and rises at end
			if (h_next == h_active.hsync_start) begin
				hsync_n <= 1'b0;
			end else if (h_next == h_active.hsync_end) begin
				hsync_n <= 1'b1;
			end

			// blank, same set and clear scheme
			if (h_next == h_active.hblank_start) begin
				hblank_n <= 1'b0;
			end else if (h_next == h_active.hblank_end) begin
				hblank_n <= 1'b1;
			end

			// one pixel wide
			hreset_n <= (h_next != HRESET_PIX);
		end
	end

	// count stays inside the active line
	a_h_in_range : assert property (
		@(posedge CLK_48M) disable iff (rst)
		h_cnt <= h_active.line_last
	);

endmodule

/* tb_video_timing.sv */
`timescale 1ns/10ps

module tb_video_timing;
	import video_timing_pkg::*;

	logic        CLK_48M = 1'b0;
	logic        rst = 1'b1;
	logic        wb_cyc = 1'b0;
	logic        wb_stb = 1'b0;
	logic        wb_we = 1'b0;
	logic [3:0]  wb_adr = '0;
	logic [15:0] wb_dat_w = '0;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        ce_6m;
	raster_pos_t raster;
	video_sync_t sync;

	// staged model, written by the bus tasks
	logic [8:0]  st_regs [0:9];
	h_timing_t   st_h;
	v_timing_t   st_v;
	// active model, swapped at the frame boundary
	h_timing_t   m_h;
	v_timing_t   m_v;
	logic        v_ok;
	logic        rd_check = 1'b0;
	logic [15:0] rd_exp = '0;
	logic [31:0] lfsr = 32'h28ef12db;
	int          errors = 0;
	int          tests = 0;
	int          cycles = 0;
	int          frame_cnt = 0;
	int          fall_cnt = 0;
	// edge history and width counters
	logic        hs_q;
	logic        hb_q;
	logic        hs_seen;
	int          hs_gap;
	int          hs_exp;
	int          hs_low;
	int          hb_low;
	logic        frame_evt;
	logic        hs_fall;
	logic        hs_rise;
	logic        hb_rise;

	video_timing_top #(.WB_ADDR_W(4), .WB_DATA_W(16)) UUT (
		.CLK_48M  (CLK_48M),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.ce_6m    (ce_6m),
		.raster   (raster),
		.sync     (sync)
	);

	// 250 MHz sim clock, stands in for 48 MHz
	always #2 CLK_48M = ~CLK_48M;

	assign st_h = '{st_regs[0], st_regs[1], st_regs[2], st_regs[3], st_regs[4]};
	assign st_v = '{st_regs[5], st_regs[6], st_regs[7], st_regs[8], st_regs[9]};

	// last pixel of the last line on a pixel strobe
	assign frame_evt = ce_6m && raster.h == m_h.line_last && raster.v == m_v.frame_last;
	assign hs_fall = hs_q & ~sync.hsync_n;
	assign hs_rise = ~hs_q & sync.hsync_n;
	assign hb_rise = ~hb_q & sync.hblank_n;

	// position inside a start/end window, wrapping windows too
	function automatic logic in_win(input logic [8:0] pos, input logic [8:0] s,
		input logic [8:0] e);
		if (s <= e) begin
			return (pos >= s) && (pos < e);
		end
		return (pos >= s) || (pos < e);
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	always @(posedge CLK_48M) begin
		cycles <= cycles + 1;
		if (rst) begin
			m_h     <= '{9'd383, 9'd272, 9'd368, 9'd304, 9'd336};
			m_v     <= '{9'd263, 9'd240, 9'd16, 9'd248, 9'd0};
			v_ok    <= 1'b0;
			hs_q    <= 1'b1;
			hb_q    <= 1'b1;
			hs_seen <= 1'b0;
			hs_gap  <= 0;
			hs_exp  <= 0;
			hs_low  <= 0;
			hb_low  <= 0;
		end else begin
			hs_q <= sync.hsync_n;
			hb_q <= sync.hblank_n;
			if (frame_evt) begin
				m_h <= st_h;
				m_v <= st_v;
				// vertical flops settle after one whole unchanged frame
				v_ok <= (st_h == m_h) && (st_v == m_v);
				// gap across the boundary follows the new sync start
				hs_exp <= hs_exp + (int'(st_h.hsync_start) - int'(m_h.hsync_start)) * 8;
				frame_cnt <= frame_cnt + 1;
			end
			if (hs_fall) begin
				hs_gap  <= 1;
				hs_seen <= 1'b1;
				hs_exp  <= (m_h.line_last + 1) * 8;
				fall_cnt <= fall_cnt + 1;
			end else begin
				hs_gap <= hs_gap + 1;
			end
			hs_low <= sync.hsync_n ? 0 : hs_low + 1;
			hb_low <= sync.hblank_n ? 0 : hb_low + 1;
		end
	end

	// run limit
	always @(posedge CLK_48M) begin
		if (cycles >= 3500000) begin
			$display("timeout: run did not finish within the cycle limit");
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// checking assertions
	//////////////////////////////

	a_reset_state : assert property (@(posedge CLK_48M) $fell(rst) |->
		sync == 6'h3f && raster == '0)
	else begin
		errors++;
		$display("CHECK FAILED sync/raster after reset sync=%h raster=%h", sync, raster);
	end

	a_ack_timing : assert property (@(posedge CLK_48M) disable iff (rst)
		$rose(wb_cyc && wb_stb) |-> !wb_ack ##1 wb_ack ##1 !wb_ack)
	else begin
		errors++;
		$display("wb_ack was not a single pulse one cycle after the request");
	end

	a_read_data : assert property (@(posedge CLK_48M) disable iff (rst)
		(wb_ack && rd_check) |-> wb_dat_r == rd_exp)
	else begin
		errors++;
		$display("CHECK FAILED wb_dat_r exp %h got %h", rd_exp, wb_dat_r);
	end

	// ce_6m once in eight cycles
	a_ce_period : assert property (@(posedge CLK_48M) disable iff (rst)
		ce_6m |=> !ce_6m [*7] ##1 ce_6m)
	else begin
		errors++;
		$display("ce_6m is not high one cycle in eight");
	end

	a_hsync_win : assert property (@(posedge CLK_48M) disable iff (rst)
		sync.hsync_n == !in_win(raster.h, m_h.hsync_start, m_h.hsync_end))
	else begin
		errors++;
		$display("CHECK FAILED hsync_n exp %h got %h at h %h",
			!in_win(raster.h, m_h.hsync_start, m_h.hsync_end), sync.hsync_n, raster.h);
	end

	a_hblank_win : assert property (@(posedge CLK_48M) disable iff (rst)
		sync.hblank_n == !in_win(raster.h, m_h.hblank_start, m_h.hblank_end))
	else begin
		errors++;
		$display("CHECK FAILED hblank_n exp %h got %h at h %h",
			!in_win(raster.h, m_h.hblank_start, m_h.hblank_end), sync.hblank_n, raster.h);
	end

	a_line_gap : assert property (@(posedge CLK_48M) disable iff (rst)
		(hs_fall && hs_seen) |-> hs_gap == hs_exp)
	else begin
		errors++;
		$display("CHECK FAILED hsync_n period exp %h got %h", hs_exp, hs_gap);
	end

	a_hsync_width : assert property (@(posedge CLK_48M) disable iff (rst)
		hs_rise |-> hs_low == (m_h.hsync_end - m_h.hsync_start) * 8)
	else begin
		errors++;
		$display("CHECK FAILED hsync_n low width exp %h got %h",
			(m_h.hsync_end - m_h.hsync_start) * 8, hs_low);
	end

	a_hblank_width : assert property (@(posedge CLK_48M) disable iff (rst)
		hb_rise |-> hb_low == (m_h.hblank_end - m_h.hblank_start) * 8)
	else begin
		errors++;
		$display("CHECK FAILED hblank_n low width exp %h got %h",
			(m_h.hblank_end - m_h.hblank_start) * 8, hb_low);
	end

	// one pixel at h 15
	a_hreset : assert property (@(posedge CLK_48M) disable iff (rst)
		sync.hreset_n == (raster.h != 9'd15))
	else begin
		errors++;
		$display("CHECK FAILED hreset_n exp %h got %h at h %h",
			(raster.h != 9'd15), sync.hreset_n, raster.h);
	end

	// sync window of line 0
	a_vreset : assert property (@(posedge CLK_48M) disable iff (rst)
		sync.vreset_n ==
		!(raster.v == 9'd0 && in_win(raster.h, m_h.hsync_start, m_h.hsync_end)))
	else begin
		errors++;
		$display("CHECK FAILED vreset_n exp %h got %h at v %h",
			!(raster.v == 9'd0 && in_win(raster.h, m_h.hsync_start, m_h.hsync_end)),
			sync.vreset_n, raster.v);
	end

	a_vsync_win : assert property (@(posedge CLK_48M) disable iff (rst || !v_ok)
		sync.vsync_n == !in_win(raster.v, m_v.vsync_start, m_v.vsync_end))
	else begin
		errors++;
		$display("CHECK FAILED vsync_n exp %h got %h at v %h",
			!in_win(raster.v, m_v.vsync_start, m_v.vsync_end), sync.vsync_n, raster.v);
	end

	a_vblank_win : assert property (@(posedge CLK_48M) disable iff (rst || !v_ok)
		sync.vblank_n == !in_win(raster.v, m_v.vblank_start, m_v.vblank_end))
	else begin
		errors++;
		$display("CHECK FAILED vblank_n exp %h got %h at v %h",
			!in_win(raster.v, m_v.vblank_start, m_v.vblank_end), sync.vblank_n, raster.v);
	end

	a_raster_wrap : assert property (@(posedge CLK_48M) disable iff (rst)
		frame_evt |=> raster == '0)
	else begin
		errors++;
		$display("CHECK FAILED raster after wrap exp %h got %h", 18'h0, raster);
	end

	//////////////////////////////
	// bus tasks and helpers
	//////////////////////////////

	task automatic wb_write(input int adr, input int dat);
		@(posedge CLK_48M);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr[3:0];
		wb_dat_w <= dat[15:0];
		do @(posedge CLK_48M); while (!wb_ack);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		if (adr < 10) begin
			st_regs[adr] = dat[8:0];
		end
	endtask

	task automatic wb_read(input int adr, input logic [15:0] exp);
		@(posedge CLK_48M);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_adr   <= adr[3:0];
		rd_exp   <= exp;
		rd_check <= 1'b1;
		do @(posedge CLK_48M); while (!wb_ack);
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		rd_check <= 1'b0;
	endtask

	task automatic read_all_regs();
		for (int i = 0; i < 10; i++) begin
			wb_read(i, {7'd0, st_regs[i]});
		end
	endtask

	// galois step per bit
	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
			v = (v << 1) | lfsr[0];
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target) @(posedge CLK_48M);
	endtask

	task automatic wait_lines(input int n);
		int target;
		target = fall_cnt + n;
		while (fall_cnt < target) @(posedge CLK_48M);
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s: done, errors so far %0d", tests, name, errors);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int r;
		int ll;
		int fl;
		int hb;
		int hs;
		int vb;
		int vs;
		st_regs = '{9'd383, 9'd272, 9'd368, 9'd304, 9'd336,
			9'd263, 9'd240, 9'd16, 9'd248, 9'd0};
		repeat (5) @(posedge CLK_48M);
		rst <= 1'b0;

		// defaults, then unmapped words
		read_all_regs();
		for (int a = 11; a < 16; a++) begin
			wb_read(a, 16'h0000);
		end
		report("reset state");

		// status ignores writes
		wb_write(10, 16'h01ff);
		read_all_regs();
		wb_write(2, 16'h0155);
		wb_read(2, 16'h0155);
		wb_write(2, 16'd368);
		wb_read(2, 16'd368);
		report("bus protocol");

		wait_lines(4);
		report("line geometry");

		// shortened geometry, edges kept below line 40
		rand_bits(5, r);
		ll = 40 + r % 24;
		rand_bits(4, r);
		hb = 1 + r;
		wb_write(0, ll);
		wb_write(1, hb);
		rand_bits(4, r);
		wb_write(2, hb + 8 + r);
		rand_bits(2, r);
		hs = hb + 1 + r;
		wb_write(3, hs);
		rand_bits(3, r);
		wb_write(4, hs + 1 + r);
		rand_bits(4, r);
		fl = 20 + r % 12;
		rand_bits(3, r);
		vb = 1 + r;
		wb_write(5, fl);
		wb_write(6, vb);
		rand_bits(3, r);
		wb_write(7, vb + 4 + r);
		rand_bits(1, r);
		vs = vb + 1 + r;
		wb_write(8, vs);
		rand_bits(1, r);
		wb_write(9, vs + 1 + r);
		wait_frames(4);
		report("frame geometry");

		// new line length staged mid frame
		while (raster.v != fl / 2) @(posedge CLK_48M);
		wb_write(0, 40 + (ll - 40 + 7) % 24);
		wait_frames(3);
		report("frame-boundary update");

		wait_frames(1);
		report("line reset");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* timing_regs.sv */
`timescale 1ns/10ps

module timing_regs #(
	parameter int WB_ADDR_W = 4,
	parameter int WB_DATA_W = 16
) (
	input  logic                          CLK_48M,
	input  logic                          rst,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [WB_ADDR_W-1:0]          wb_adr,
	input  logic [WB_DATA_W-1:0]          wb_dat_w,
	output logic [WB_DATA_W-1:0]          wb_dat_r,
	output logic                          wb_ack,
	input  logic                          frame_start,
	input  video_timing_pkg::raster_pos_t raster,
	output video_timing_pkg::h_timing_t   h_active,
	output video_timing_pkg::v_timing_t   v_active
);
	import video_timing_pkg::*;

	// sets written by the bus, applied at frame start
	h_timing_t h_stage;
	v_timing_t v_stage;

	logic                 bus_req;
	logic [8:0]           wr_val;
	logic                 upd_pending;
	logic [15:0]          status_word;
	logic [WB_DATA_W-1:0] rd_word;

	// new request only once the previous ack has dropped
	assign bus_req = wb_cyc & wb_stb & ~wb_ack;
	// geometry fields are 9 bits wide
	assign wr_val = wb_dat_w[8:0];

	// staged values still waiting for the frame boundary
	assign upd_pending = (h_stage != h_active) | (v_stage != v_active);

	// line count low, coarse column above, pending flag on top
	assign status_word = {upd_pending, raster.h[8:3], raster.v};

	//////////////////////////////
	// read mux
	//////////////////////////////

	always_comb begin
		rd_word = '0;
		case (wb_adr)
			REG_LINE_LAST:    rd_word[8:0] = h_stage.line_last;
			REG_HBLANK_START: rd_word[8:0] = h_stage.hblank_start;
			REG_HBLANK_END:   rd_word[8:0] = h_stage.hblank_end;
			REG_HSYNC_START:  rd_word[8:0] = h_stage.hsync_start;
			REG_HSYNC_END:    rd_word[8:0] = h_stage.hsync_end;
			REG_FRAME_LAST:   rd_word[8:0] = v_stage.frame_last;
			REG_VBLANK_START: rd_word[8:0] = v_stage.vblank_start;
			REG_VBLANK_END:   rd_word[8:0] = v_stage.vblank_end;
			REG_VSYNC_START:  rd_word[8:0] = v_stage.vsync_start;
			REG_VSYNC_END:    rd_word[8:0] = v_stage.vsync_end;
			REG_STATUS:       rd_word = WB_DATA_W'(status_word);
			// unmapped reads as zero
			default:          rd_word = '0;
		endcase
	end

	//////////////////////////////
	// bus handshake and sets
	//////////////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			h_stage  <= H_DEFAULT;
			v_stage  <= V_DEFAULT;
			h_active <= H_DEFAULT;
			v_active <= V_DEFAULT;
		end else begin
			// single cycle ack
			wb_ack <= bus_req;

			if (bus_req && wb_we) begin
				case (wb_adr)
					REG_LINE_LAST:    h_stage.line_last    <= wr_val;
					REG_HBLANK_START: h_stage.hblank_start <= wr_val;
					REG_HBLANK_END:   h_stage.hblank_end   <= wr_val;
					REG_HSYNC_START:  h_stage.hsync_start  <= wr_val;
					REG_HSYNC_END:    h_stage.hsync_end    <= wr_val;
					REG_FRAME_LAST:   v_stage.frame_last   <= wr_val;
					REG_VBLANK_START: v_stage.vblank_start <= wr_val;
					REG_VBLANK_END:   v_stage.vblank_end   <= wr_val;
					REG_VSYNC_START:  v_stage.vsync_start  <= wr_val;
					REG_VSYNC_END:    v_stage.vsync_end    <= wr_val;
					// status and unmapped ignore writes
					default: ;
				endcase
			end

			// whole sets swap at once, frame never torn
			if (frame_start) begin
				h_active <= h_stage;
				v_active <= v_stage;
			end
		end
	end

	// read data held with ack
	always_ff @(posedge CLK_48M) begin
		if (bus_req) begin
			wb_dat_r <= rd_word;
		end
	end

	// ack only answers a live request
	a_ack_after_req : assert property (
		@(posedge CLK_48M) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	);

	// ack is one cycle wide
	a_ack_single : assert property (
		@(posedge CLK_48M) disable iff (rst)
		wb_ack |=> !wb_ack
	);

endmodule

/* vertical_timing.sv */
`timescale 1ns/10ps

module vertical_timing (
	input  logic                        CLK_48M,
	input  logic                        rst,
	input  logic                        line_done,
	input  logic                        hsync_n,
	input  video_timing_pkg::v_timing_t v_active,
	output logic [8:0]                  v_pos,
	output logic                        vsync_n,
	output logic                        vblank_n,
	output logic                        vreset_n,
	output logic                        frame_start
);

	logic [8:0] v_cnt;
	logic [8:0] v_next;
	logic       v_wrap;
	logic       v_zero;

	//////////////////////////////
	// line counter
	//////////////////////////////

	assign v_wrap = (v_cnt == v_active.frame_last);
	assign v_next = v_wrap ? 9'd0 : v_cnt + 9'd1;
	assign v_zero = (v_cnt == 9'd0);

	// last line done, next one is line 0
	assign frame_start = line_done & v_wrap;
	assign v_pos       = v_cnt;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_cnt <= 9'd0;
		end else if (line_done) begin
			v_cnt <= v_next;
		end
	end

	//////////////////////////////
	// sync and blank flops
	//////////////////////////////

	// edges land on the line_done into the matching line
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			vsync_n  <= 1'b1;
			vblank_n <= 1'b1;
		end else if (line_done) begin
			if (v_next == v_active.vsync_start) begin
				vsync_n <= 1'b0;
			end else if (v_next == v_active.vsync_end) begin
				vsync_n <= 1'b1;
			end

			if (v_next == v_active.vblank_start) begin
				vblank_n <= 1'b0;
			end else if (v_next == v_active.vblank_end) begin
				vblank_n <= 1'b1;
			end
		end
	end

	// frame reset, hsync period of line 0
	// both terms come straight from flops
	assign vreset_n = ~(v_zero & ~hsync_n);

	// line count stays inside the active frame
	a_v_in_range : assert property (
		@(posedge CLK_48M) disable iff (rst)
		v_cnt <= v_active.frame_last
	);

endmodule

/* video_timing_pkg.sv */
package video_timing_pkg;

	//////////////////////////////
	// geometry sets
	//////////////////////////////

	// horizontal set, all values in pixel clocks from line start
	typedef struct packed {
		// last pixel of the line, count wraps after it
		logic [8:0] line_last;
		logic [8:0] hblank_start;
		logic [8:0] hblank_end;
		logic [8:0] hsync_start;
		logic [8:0] hsync_end;
	} h_timing_t;

	// vertical set, all values are line numbers
	typedef struct packed {
		logic [8:0] frame_last;
		logic [8:0] vblank_start;
		logic [8:0] vblank_end;
		logic [8:0] vsync_start;
		logic [8:0] vsync_end;
	} v_timing_t;

	//////////////////////////////
	// video outputs
	//////////////////////////////

	// all active low, as on the board
	typedef struct packed {
		logic hsync_n;
		logic hblank_n;
		logic hreset_n;
		logic vsync_n;
		logic vblank_n;
		logic vreset_n;
	} video_sync_t;

	// low bits double as 1H 2H 4H and 1V
	typedef struct packed {
		logic [8:0] h;
		logic [8:0] v;
	} raster_pos_t;

	// original board geometry, 384 x 264
	localparam h_timing_t H_DEFAULT = '{9'd383, 9'd272, 9'd368, 9'd304, 9'd336};
	localparam v_timing_t V_DEFAULT = '{9'd263, 9'd240, 9'd16, 9'd248, 9'd0};

	//////////////////////////////
	// register map, word addresses
	//////////////////////////////

	localparam int REG_LINE_LAST    = 0;
	localparam int REG_HBLANK_START = 1;
	localparam int REG_HBLANK_END   = 2;
	localparam int REG_HSYNC_START  = 3;
	localparam int REG_HSYNC_END    = 4;
	localparam int REG_FRAME_LAST   = 5;
	localparam int REG_VBLANK_START = 6;
	localparam int REG_VBLANK_END   = 7;
	localparam int REG_VSYNC_START  = 8;
	localparam int REG_VSYNC_END    = 9;
	// read only
	localparam int REG_STATUS       = 10;

endpackage

/* video_timing_top.sv */
`timescale 1ns/10ps

module video_timing_top #(
	parameter int WB_ADDR_W = 4,
	parameter int WB_DATA_W = 16
) (
	input  logic                          CLK_48M,
	input  logic                          rst,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [WB_ADDR_W-1:0]          wb_adr,
	input  logic [WB_DATA_W-1:0]          wb_dat_w,
	output logic [WB_DATA_W-1:0]          wb_dat_r,
	output logic                          wb_ack,
	output logic                          ce_6m,
	output video_timing_pkg::raster_pos_t raster,
	output video_timing_pkg::video_sync_t sync
);
	import video_timing_pkg::*;

	// active geometry from the register block
	h_timing_t  h_active;
	v_timing_t  v_active;

	logic [8:0] h_pos;
	logic [8:0] v_pos;
	logic       hsync_n;
	logic       hblank_n;
	logic       hreset_n;
	logic       vsync_n;
	logic       vblank_n;
	logic       vreset_n;
	logic       line_done;
	logic       frame_start;

	//////////////////////////////
	// divider
	//////////////////////////////

	// faster strobes not needed by the counters
	clock_enable_gen u_clock_enable_gen (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.ce_24m  (),
		.ce_12m  (),
		.ce_6m   (ce_6m)
	);

	// geometry registers
	timing_regs #(
		.WB_ADDR_W (WB_ADDR_W),
		.WB_DATA_W (WB_DATA_W)
	) u_timing_regs (
		.CLK_48M     (CLK_48M),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.frame_start (frame_start),
		.raster      (raster),
		.h_active    (h_active),
		.v_active    (v_active)
	);

	//////////////////////////////
	// counters
	//////////////////////////////

	horizontal_timing u_horizontal_timing (
		.CLK_48M   (CLK_48M),
		.rst       (rst),
		.ce_6m     (ce_6m),
		.h_active  (h_active),
		.h_pos     (h_pos),
		.hsync_n   (hsync_n),
		.hblank_n  (hblank_n),
		.hreset_n  (hreset_n),
		.line_done (line_done)
	);

	// steps once per line
	vertical_timing u_vertical_timing (
		.CLK_48M     (CLK_48M),
		.rst         (rst),
		.line_done   (line_done),
		.hsync_n     (hsync_n),
		.v_active    (v_active),
		.v_pos       (v_pos),
		.vsync_n     (vsync_n),
		.vblank_n    (vblank_n),
		.vreset_n    (vreset_n),
		.frame_start (frame_start)
	);

	// pack outputs
	assign raster = '{h: h_pos, v: v_pos};
	assign sync   = '{hsync_n, hblank_n, hreset_n, vsync_n, vblank_n, vreset_n};

endmodule
